/* bench/stq_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store queue testbench.
// table-driven probes against a queue
// model, plus drain and credit checks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "stq_params.svh"

module stq_tb;
  import stq_pkg::*;

  typedef struct packed {
    logic [1:0] n_st;
    lsaddr_u    a0;
    ls_size_e   s0;
    lsaddr_u    a1;
    ls_size_e   s1;
    lsaddr_u    pa;
    ls_size_e   ps;
    logic       hit;
    logic       part;
  } vec_s;

  logic        clk;
  logic        arst_n;
  logic        st_valid;
  st_req_s     st;
  logic        st_credit;
  logic        commit;
  logic        chk_valid;
  chk_req_s    chk;
  logic        rsp_valid;
  chk_rsp_s    rsp;
  logic        wb_valid;
  wb_req_s     wb;
  logic        wb_credit = 1'b0;

  vec_s        tbl[$];
  string       tbl_name[$];
  wb_req_s     mdl_q[$];
  string       cur_name = "reset_outputs";
  int          errors = 0;
  int          mon_errors = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  int          test_err0 = 0;
  int          pushed = 0;
  int          sc_seen = 0;
  int          wb_seen = 0;
  int          cred_back = 0;
  bit          cache_auto = 1'b1;
  int unsigned seed_dummy;

  stq_top uut (
    .clk       (clk),
    .arst_n    (arst_n),
    .st_valid  (st_valid),
    .st        (st),
    .st_credit (st_credit),
    .commit    (commit),
    .chk_valid (chk_valid),
    .chk       (chk),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .wb_valid  (wb_valid),
    .wb        (wb),
    .wb_credit (wb_credit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // cache side and output monitor.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one credit back per write seen.
  always @(posedge clk) begin
    if (cache_auto && wb_seen > cred_back) begin
      wb_credit <= 1'b1;
      cred_back <= cred_back + 1;
    end else begin
      wb_credit <= 1'b0;
    end
  end

  always @(negedge clk) begin
    wb_req_s want_wb;
    if (arst_n) begin
      if (st_credit) sc_seen++;
      if (wb_valid != st_credit) begin
        $display("Error in %s: st_credit did not pulse with wb_valid", cur_name);
        mon_errors++;
      end
      if (wb_valid) begin
        wb_seen++;
        if (mdl_q.size() == 0) begin
          $display("Error in %s: cache write with no store left in the queue", cur_name);
          mon_errors++;
        end else begin
          want_wb = mdl_q.pop_front();
          if (wb !== want_wb) begin
            $display("Mismatch %s: wb expected %h actual %h", cur_name, want_wb, wb);
            mon_errors++;
          end
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // 1, 2 or 4 bytes starting at the offset.
  function automatic logic [3:0] lane_mask(input logic [1:0] off, input ls_size_e sz);
    logic [4:0] ones;
    ones = (5'd1 << (3'd1 << sz)) - 5'd1;
    return ones[3:0] << off;
  endfunction

  function automatic chk_rsp_s model_forward(input lsaddr_u a, input ls_size_e sz);
    chk_rsp_s   r;
    logic [3:0] m;
    int         cov;
    int         ovl;
    m   = lane_mask(a.fields.off, sz);
    cov = -1;
    ovl = -1;
    foreach (mdl_q[k]) begin
      if (mdl_q[k].word == a.fields.word) begin
        if ((mdl_q[k].mask & m) == m) begin
          cov = k;
        end else if ((mdl_q[k].mask & m) != 4'b0000) begin
          ovl = k;
        end
      end
    end
    // a younger partial overlap blocks forwarding.
    r.partial = ovl > cov;
    r.hit     = cov >= 0 && !r.partial;
    r.data    = '0;
    for (int b = 0; b < 4; b++) begin
      if (r.hit && m[b]) r.data[8*b +: 8] = mdl_q[cov].data[8*b +: 8];
    end
    return r;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus tasks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic stop_on_timeout(input string why);
    $display("Error in %s: %s", cur_name, why);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic add_vec(input string name, input logic [1:0] n,
                         input lsaddr_u a0, input ls_size_e s0,
                         input lsaddr_u a1, input ls_size_e s1,
                         input lsaddr_u pa, input ls_size_e ps,
                         input logic hit, input logic part);
    vec_s v;
    v.n_st = n;
    v.a0   = a0;
    v.s0   = s0;
    v.a1   = a1;
    v.s1   = s1;
    v.pa   = pa;
    v.ps   = ps;
    v.hit  = hit;
    v.part = part;
    tbl.push_back(v);
    tbl_name.push_back(name);
  endtask

  task automatic push_store(input lsaddr_u a, input ls_size_e sz);
    wb_req_s ent;
    if (`STQ_DEPTH - pushed + sc_seen <= 0) begin
      $display("Error in %s: store sent with no producer credit", cur_name);
      errors++;
    end
    ent.word = a.fields.word;
    ent.mask = lane_mask(a.fields.off, sz);
    ent.data = $urandom;
    @(posedge clk);
    st_valid <= 1'b1;
    st.addr  <= a;
    st.size  <= sz;
    st.data  <= ent.data;
    mdl_q.push_back(ent);
    pushed++;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    st_valid  <= 1'b0;
    chk_valid <= 1'b0;
    commit    <= 1'b0;
  endtask

  task automatic commit_stores(input int n);
    repeat (n) begin
      @(posedge clk);
      commit <= 1'b1;
    end
    @(posedge clk);
    commit <= 1'b0;
  endtask

  // response is due in the second cycle after chk_valid.
  task automatic check_probe(input lsaddr_u a, input ls_size_e sz,
                             input logic hit, input logic part);
    chk_rsp_s want;
    int       n;
    want = model_forward(a, sz);
    if (want.hit != hit || want.partial != part) begin
      $display("Error in %s: table flags disagree with the queue model", cur_name);
      errors++;
    end
    @(posedge clk);
    chk_valid <= 1'b1;
    chk.addr  <= a;
    chk.size  <= sz;
    @(posedge clk);
    chk_valid <= 1'b0;
    n = 1;
    @(negedge clk);
    while (!rsp_valid && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!rsp_valid) begin
      stop_on_timeout("no load response within 20 cycles");
    end else begin
      if (n != 2) begin
        $display("Mismatch %s: latency expected 2 actual %0d", cur_name, n);
        errors++;
      end
      if (rsp.hit !== want.hit) begin
        $display("Mismatch %s: hit expected %b actual %b", cur_name, want.hit, rsp.hit);
        errors++;
      end
      if (rsp.partial !== want.partial) begin
        $display("Mismatch %s: partial expected %b actual %b", cur_name, want.partial,
                 rsp.partial);
        errors++;
      end
      if (rsp.data !== want.data) begin
        $display("Mismatch %s: data expected %h actual %h", cur_name, want.data, rsp.data);
        errors++;
      end
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while ((mdl_q.size() != 0 || cred_back != wb_seen) && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (mdl_q.size() != 0 || cred_back != wb_seen) begin
      stop_on_timeout("queue did not drain within 200 cycles");
    end
  endtask

  task automatic close_test();
    if (errors + mon_errors == test_err0) begin
      $display("test %s : pass", cur_name);
      n_pass++;
    end else begin
      $display("test %s : fail", cur_name);
      n_fail++;
    end
    test_err0 = errors + mon_errors;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int n;
    int base;
    seed_dummy = $urandom(32'hbe49_4f7f);
    arst_n    <= 1'b0;
    st_valid  <= 1'b0;
    st        <= '0;
    commit    <= 1'b0;
    chk_valid <= 1'b0;
    chk       <= '0;
    add_vec("byte_fwd", 2'd1, 32'h100, SZ_WORD, 32'h0, SZ_BYTE, 32'h102, SZ_BYTE, 1, 0);
    add_vec("younger_wins", 2'd2, 32'h200, SZ_WORD, 32'h200, SZ_WORD, 32'h202, SZ_HALF, 1, 0);
    add_vec("half_vs_word", 2'd1, 32'h300, SZ_HALF, 32'h0, SZ_BYTE, 32'h300, SZ_WORD, 0, 1);
    add_vec("miss", 2'd1, 32'h400, SZ_WORD, 32'h0, SZ_BYTE, 32'h500, SZ_BYTE, 0, 0);
    add_vec("younger_overlap", 2'd2, 32'h600, SZ_WORD, 32'h601, SZ_BYTE, 32'h600, SZ_HALF,
            0, 1);
    add_vec("older_overlap", 2'd2, 32'h701, SZ_BYTE, 32'h700, SZ_WORD, 32'h700, SZ_HALF,
            1, 0);
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    if (st_credit || rsp_valid || wb_valid) begin
      $display("Error in %s: outputs not idle after reset", cur_name);
      errors++;
    end
    close_test();

    foreach (tbl[i]) begin
      cur_name = tbl_name[i];
      push_store(tbl[i].a0, tbl[i].s0);
      if (tbl[i].n_st == 2'd2) push_store(tbl[i].a1, tbl[i].s1);
      idle_cycle();
      check_probe(tbl[i].pa, tbl[i].ps, tbl[i].hit, tbl[i].part);
      commit_stores(int'(tbl[i].n_st));
      wait_drained();
      close_test();
    end

    // cache holds back its credits until two writes went out.
    cur_name   = "credit_drain";
    cache_auto = 1'b0;
    base       = wb_seen;
    for (int k = 0; k < 4; k++) push_store(32'h800 + 4 * k, SZ_WORD);
    idle_cycle();
    commit_stores(4);
    n = 0;
    while (wb_seen - base < `STQ_WB_CREDITS_INIT && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (wb_seen - base < `STQ_WB_CREDITS_INIT) stop_on_timeout("no cache write within 50 cycles");
    repeat (10) @(negedge clk);
    if (wb_seen - base != `STQ_WB_CREDITS_INIT) begin
      $display("Mismatch %s: writes expected %0d actual %0d", cur_name,
               `STQ_WB_CREDITS_INIT, wb_seen - base);
      errors++;
    end
    cache_auto = 1'b1;
    wait_drained();
    close_test();

    cur_name = "refill";
    if (sc_seen != pushed) begin
      $display("Mismatch %s: st_credit pulses expected %0d actual %0d", cur_name, pushed,
               sc_seen);
      errors++;
    end
    // last store of the credit test, drained but still held in its slot.
    check_probe(32'h80c, SZ_WORD, 0, 0);
    for (int k = 0; k < `STQ_DEPTH; k++) push_store(32'h900 + 4 * k, SZ_WORD);
    idle_cycle();
    if (`STQ_DEPTH - pushed + sc_seen != 0) begin
      $display("Mismatch %s: producer credits expected 0 actual %0d", cur_name,
               `STQ_DEPTH - pushed + sc_seen);
      errors++;
    end
    check_probe(32'h905, SZ_BYTE, 1, 0);
    commit_stores(`STQ_DEPTH);
    wait_drained();
    if (sc_seen != pushed) begin
      $display("Mismatch %s: st_credit pulses expected %0d actual %0d", cur_name, pushed,
               sc_seen);
      errors++;
    end
    close_test();

    $display("tests %0d, passed %0d, failed %0d, errors %0d", n_pass + n_fail, n_pass,
             n_fail, errors + mon_errors);
    if (n_fail == 0 && errors + mon_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* rtl/stq_addr_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address decode stage.
// registers the word address and the
// byte lane mask of one access.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module stq_addr_decode (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                in_valid,
  input  stq_pkg::lsaddr_u    addr,
  input  stq_pkg::ls_size_e   size,
  output logic                out_valid,
  output stq_pkg::dec_addr_s  dec
);
  import stq_pkg::*;

  dec_addr_s dec_d;

  always_comb begin
    dec_d.word = addr.fields.word;
    case (size)
      SZ_BYTE: dec_d.mask = 4'b0001 << addr.fields.off;
      SZ_HALF: dec_d.mask = 4'b0011 << addr.fields.off;
      default: dec_d.mask = 4'b1111;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    dec <= dec_d;
  end

  // accesses never cross a word.
  a_half_aligned : assert property (@(posedge clk) disable iff (!arst_n)
    in_valid && size == SZ_HALF |-> !addr.raw[0])
    else $error("stq_addr_decode: half access at odd offset");

  a_word_aligned : assert property (@(posedge clk) disable iff (!arst_n)
    in_valid && size == SZ_WORD |-> addr.raw[1:0] == 2'b00)
    else $error("stq_addr_decode: word access at nonzero offset");

endmodule

/* rtl/stq_entry_array.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store queue entries.
// circular buffer with head, commit and
// tail pointers, plus the probe compare.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "stq_params.svh"

module stq_entry_array (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic                                   enq_valid,
  input  stq_pkg::dec_addr_s                     enq_dec,
  input  logic [`STQ_DATA_W-1:0]                 enq_data,
  input  logic                                   commit,
  input  logic                                   probe_valid,
  input  stq_pkg::dec_addr_s                     probe,
  output logic [`STQ_DEPTH-1:0]                  cover_vec,
  output logic [`STQ_DEPTH-1:0]                  overlap_vec,
  output logic [`STQ_IDX_W-1:0]                  age_ptr,
  output logic [`STQ_DEPTH-1:0][`STQ_DATA_W-1:0] entry_data,
  input  logic                                   deq,
  output logic                                   head_ready,
  output stq_pkg::wb_req_s                       head,
  output logic                                   freed
);
  import stq_pkg::*;

  dec_addr_s              ent_addr_q [`STQ_DEPTH];
  logic [`STQ_DATA_W-1:0] ent_data_q [`STQ_DEPTH];
  logic [`STQ_DEPTH-1:0]  valid_q;
  logic [`STQ_DEPTH-1:0]  cmt_q;
  logic [`STQ_IDX_W-1:0]  head_ptr;
  logic [`STQ_IDX_W-1:0]  cmt_ptr;
  logic [`STQ_IDX_W-1:0]  tail_ptr;
  logic                   can_commit;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointers and state bits.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // commit may land on the store being written this cycle.
  assign can_commit = (valid_q[cmt_ptr] && !cmt_q[cmt_ptr]) ||
                      (enq_valid && cmt_ptr == tail_ptr && !valid_q[tail_ptr]);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q  <= '0;
      cmt_q    <= '0;
      head_ptr <= '0;
      cmt_ptr  <= '0;
      tail_ptr <= '0;
    end else begin
      if (deq) begin
        valid_q[head_ptr] <= 1'b0;
        cmt_q[head_ptr]   <= 1'b0;
        head_ptr          <= head_ptr + 1'b1;
      end
      if (enq_valid) begin
        valid_q[tail_ptr] <= 1'b1;
        cmt_q[tail_ptr]   <= 1'b0;
        tail_ptr          <= tail_ptr + 1'b1;
      end
      // last write wins over the enqueue clear.
      if (commit) begin
        cmt_q[cmt_ptr] <= 1'b1;
        cmt_ptr        <= cmt_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (enq_valid) begin
      ent_addr_q[tail_ptr] <= enq_dec;
      ent_data_q[tail_ptr] <= enq_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // probe compare, one per entry.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar i = 0; i < `STQ_DEPTH; i++) begin : g_cmp
    logic       same_word;
    logic [3:0] shared;

    assign same_word      = valid_q[i] && ent_addr_q[i].word == probe.word;
    assign shared         = ent_addr_q[i].mask & probe.mask;
    assign cover_vec[i]   = probe_valid && same_word && shared == probe.mask;
    assign overlap_vec[i] = probe_valid && same_word && |shared && shared != probe.mask;
    assign entry_data[i]  = ent_data_q[i];
  end

  assign age_ptr = head_ptr;

  // oldest committed store goes to the cache.
  assign head_ready = valid_q[head_ptr] && cmt_q[head_ptr];
  assign head.word  = ent_addr_q[head_ptr].word;
  assign head.mask  = ent_addr_q[head_ptr].mask;
  assign head.data  = ent_data_q[head_ptr];
  assign freed      = deq;

  a_no_enq_full : assert property (@(posedge clk) disable iff (!arst_n)
    enq_valid |-> !valid_q[tail_ptr])
    else $error("stq_entry_array: enqueue into a full queue");

  a_commit_pending : assert property (@(posedge clk) disable iff (!arst_n)
    commit |-> can_commit)
    else $error("stq_entry_array: commit with no uncommitted store");

endmodule

/* rtl/stq_forward_select.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load forward select.
// youngest covering store wins unless a
// younger store overlaps the load.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "stq_params.svh"

module stq_forward_select (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic                                   probe_valid,
  input  logic [3:0]                             probe_mask,
  input  logic [`STQ_DEPTH-1:0]                  cover_vec,
  input  logic [`STQ_DEPTH-1:0]                  overlap_vec,
  input  logic [`STQ_IDX_W-1:0]                  age_ptr,
  input  logic [`STQ_DEPTH-1:0][`STQ_DATA_W-1:0] entry_data,
  output logic                                   rsp_valid,
  output stq_pkg::chk_rsp_s                      rsp
);
  import stq_pkg::*;

  logic                   cov_any;
  logic                   ovl_any;
  logic [`STQ_IDX_W-1:0]  cov_pos;
  logic [`STQ_IDX_W-1:0]  ovl_pos;
  logic [`STQ_IDX_W-1:0]  cov_idx;
  logic                   partial;
  logic [`STQ_DATA_W-1:0] lane_bits;
  chk_rsp_s               rsp_d;

  // walk oldest to youngest, last hit is the youngest.
  always_comb begin
    logic [`STQ_IDX_W-1:0] idx;
    cov_any = 1'b0;
    ovl_any = 1'b0;
    cov_pos = '0;
    ovl_pos = '0;
    for (int j = 0; j < `STQ_DEPTH; j++) begin
      idx = age_ptr + `STQ_IDX_W'(j);
      if (cover_vec[idx]) begin
        cov_any = 1'b1;
        cov_pos = `STQ_IDX_W'(j);
      end
      if (overlap_vec[idx]) begin
        ovl_any = 1'b1;
        ovl_pos = `STQ_IDX_W'(j);
      end
    end
  end

  assign cov_idx = age_ptr + cov_pos;
  assign partial = ovl_any && (!cov_any || ovl_pos > cov_pos);

  for (genvar b = 0; b < 4; b++) begin : g_lane
    assign lane_bits[8*b +: 8] = {8{probe_mask[b]}};
  end

  always_comb begin
    rsp_d.hit     = probe_valid && cov_any && !partial;
    rsp_d.partial = probe_valid && partial;
    rsp_d.data    = rsp_d.hit ? (entry_data[cov_idx] & lane_bits) : '0;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= probe_valid;
    end
  end

  always_ff @(posedge clk) begin
    rsp <= rsp_d;
  end

endmodule

/* rtl/stq_params.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store queue sizing.
// depth, widths and the cache credit
// pool held after reset.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef STQ_PARAMS_SVH
`define STQ_PARAMS_SVH

// entries and index width, kept in step.
`define STQ_DEPTH 8
`define STQ_IDX_W 3

// one data word, four byte lanes.
`define STQ_DATA_W 32

// byte address width.
`define STQ_ADDR_W 32

// cache write credits after reset.
`define STQ_WB_CREDITS_INIT 2

`endif

/* rtl/stq_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store queue types.
// address views, access sizes and the
// request and response records.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "stq_params.svh"

package stq_pkg;

  // byte address, or word address plus lane offset.
  typedef union packed {
    logic [`STQ_ADDR_W-1:0] raw;
    struct packed {
      logic [`STQ_ADDR_W-3:0] word;
      logic [1:0]             off;
    } fields;
  } lsaddr_u;

  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } ls_size_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request and response records.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    lsaddr_u                addr;
    ls_size_e               size;
    logic [`STQ_DATA_W-1:0] data;
  } st_req_s;

  typedef struct packed {
    lsaddr_u  addr;
    ls_size_e size;
  } chk_req_s;

  // lane mask, one bit per byte of the word.
  typedef struct packed {
    logic [`STQ_ADDR_W-3:0] word;
    logic [3:0]             mask;
  } dec_addr_s;

  typedef struct packed {
    logic                   hit;
    logic                   partial;
    logic [`STQ_DATA_W-1:0] data;
  } chk_rsp_s;

  typedef struct packed {
    logic [`STQ_ADDR_W-3:0] word;
    logic [3:0]             mask;
    logic [`STQ_DATA_W-1:0] data;
  } wb_req_s;

endpackage

/* rtl/stq_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store queue top.
// decode, entry array, forward select
// and cache drain.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "stq_params.svh"

module stq_top (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              st_valid,
  input  stq_pkg::st_req_s  st,
  output logic              st_credit,
  input  logic              commit,
  input  logic              chk_valid,
  input  stq_pkg::chk_req_s chk,
  output logic              rsp_valid,
  output stq_pkg::chk_rsp_s rsp,
  output logic              wb_valid,
  output stq_pkg::wb_req_s  wb,
  input  logic              wb_credit
);
  import stq_pkg::*;

  logic                                   enq_valid;
  dec_addr_s                              enq_dec;
  logic [`STQ_DATA_W-1:0]                 st_data_q;
  logic                                   probe_valid;
  dec_addr_s                              probe_dec;
  logic [`STQ_DEPTH-1:0]                  cover_vec;
  logic [`STQ_DEPTH-1:0]                  overlap_vec;
  logic [`STQ_IDX_W-1:0]                  age_ptr;
  logic [`STQ_DEPTH-1:0][`STQ_DATA_W-1:0] entry_data;
  logic                                   deq;
  logic                                   head_ready;
  wb_req_s                                head;

  // data lines up with the decoded store.
  always_ff @(posedge clk) begin
    st_data_q <= st.data;
  end

  stq_addr_decode st_dec (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (st_valid),
    .addr      (st.addr),
    .size      (st.size),
    .out_valid (enq_valid),
    .dec       (enq_dec)
  );

  stq_addr_decode chk_dec (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (chk_valid),
    .addr      (chk.addr),
    .size      (chk.size),
    .out_valid (probe_valid),
    .dec       (probe_dec)
  );

  stq_entry_array u_entries (
    .clk         (clk),
    .arst_n      (arst_n),
    .enq_valid   (enq_valid),
    .enq_dec     (enq_dec),
    .enq_data    (st_data_q),
    .commit      (commit),
    .probe_valid (probe_valid),
    .probe       (probe_dec),
    .cover_vec   (cover_vec),
    .overlap_vec (overlap_vec),
    .age_ptr     (age_ptr),
    .entry_data  (entry_data),
    .deq         (deq),
    .head_ready  (head_ready),
    .head        (head),
    .freed       (st_credit)
  );

  stq_forward_select u_fwd (
    .clk         (clk),
    .arst_n      (arst_n),
    .probe_valid (probe_valid),
    .probe_mask  (probe_dec.mask),
    .cover_vec   (cover_vec),
    .overlap_vec (overlap_vec),
    .age_ptr     (age_ptr),
    .entry_data  (entry_data),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp)
  );

  stq_wb_drain u_drain (
    .clk        (clk),
    .arst_n     (arst_n),
    .head_ready (head_ready),
    .head       (head),
    .wb_credit  (wb_credit),
    .deq        (deq),
    .wb_valid   (wb_valid),
    .wb         (wb)
  );

endmodule

/* rtl/stq_wb_drain.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writeback drain.
// issues committed stores to the cache
// while cache credits remain.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "stq_params.svh"

module stq_wb_drain (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             head_ready,
  input  stq_pkg::wb_req_s head,
  input  logic             wb_credit,
  output logic             deq,
  output logic             wb_valid,
  output stq_pkg::wb_req_s wb
);

  // one spare bit so an overflow stays visible.
  localparam int CRED_W = $clog2(`STQ_WB_CREDITS_INIT + 1) + 1;

  logic [CRED_W-1:0] cred_q;
  logic              issue;

  assign issue    = head_ready && cred_q != '0;
  assign deq      = issue;
  assign wb_valid = issue;
  assign wb       = head;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cred_q <= CRED_W'(`STQ_WB_CREDITS_INIT);
    end else begin
      cred_q <= cred_q + CRED_W'(wb_credit) - CRED_W'(issue);
    end
  end

  // cache returns no more than it handed out.
  a_cred_bound : assert property (@(posedge clk) disable iff (!arst_n)
    cred_q <= CRED_W'(`STQ_WB_CREDITS_INIT))
    else $error("stq_wb_drain: credit counter above initial pool");

endmodule

/* run.sh */
#!/bin/sh
# build the store queue testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module stq_tb -o stq_sim
./obj_dir/stq_sim > sim.log
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi

/* tb.f */
+incdir+rtl
rtl/stq_pkg.sv
rtl/stq_addr_decode.sv
rtl/stq_entry_array.sv
rtl/stq_forward_select.sv
rtl/stq_wb_drain.sv
rtl/stq_top.sv
bench/stq_tb.sv
